/* Makefile */
# Verilator build and run of the interrupt and sleep unit testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, pass if the log has the pass line"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f project.f \
		--top-module tb_irq_sleep -Mdir obj_dir -o sim_irq_sleep
	./obj_dir/sim_irq_sleep | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* irq_arbiter.sv */
// -------------------------------------------------------------------
// Interrupt arbiter
// Fixed-priority winner, global enable and credit-based acknowledge
// -------------------------------------------------------------------

`timescale 1ns/1ns

`include "irq_settings.svh"

module irq_arbiter
  import irq_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  irq_vec_t  pending_i,
  input  logic      mstatus_mie_i,
  input  priv_lvl_e priv_lvl_i,

  // Core returns one credit once its handler has taken the interrupt
  input  logic      irq_credit_i,

  output logic      irq_ack_o,
  output irq_id_t   irq_id_o
);

  localparam int CRED_W = $clog2(`IRQ_CREDITS + 1);

  logic        win_valid;
  irq_id_t     win_id;
  logic        eligible;
  logic        has_credit;
  logic [CRED_W-1:0] credit_q;

  // ------------------------------------------------------------------
  // Priority encoder
  // ------------------------------------------------------------------

  // Lowest priority first, later hits override earlier ones.
  // Order is 31..16, then 11, then 3, then 7
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pending_i[7]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(7);
    end
    if (pending_i[3]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(3);
    end
    if (pending_i[11]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(11);
    end
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pending_i[i]) begin
        win_valid = 1'b1;
        win_id    = irq_id_t'(i);
      end
    end
  end

  // M-mode needs mstatus.MIE, U-mode takes any enabled pending line
  assign eligible = ((priv_lvl_i == PRIV_LVL_M) && mstatus_mie_i) ||
                    ((priv_lvl_i == PRIV_LVL_U) && (|pending_i));

  // ------------------------------------------------------------------
  // Credit counter
  // ------------------------------------------------------------------

  assign has_credit = (credit_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CRED_W'(`IRQ_CREDITS);
    end else begin
      // Return and consume in the same cycle cancel out
      case ({irq_credit_i, irq_ack_o})
        2'b10: begin
          if (credit_q < CRED_W'(`IRQ_CREDITS)) begin
            credit_q <= credit_q + 1'b1;
          end
        end
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Without a credit the winner simply waits, the line is level-held
  assign irq_ack_o = win_valid && eligible && has_credit;
  assign irq_id_o  = irq_ack_o ? win_id : '0;

endmodule

/* irq_pkg.sv */
// -------------------------------------------------------------------
// Interrupt and sleep unit package
// Types shared by the interrupt and the sleep pipelines
// -------------------------------------------------------------------

`include "irq_settings.svh"

package irq_pkg;

  // ------------------------------------------------------------------
  // Interrupt types
  // ------------------------------------------------------------------

  // One bit per interrupt line, as in mip and mie
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;

  // Interrupt number reported with the acknowledge
  typedef logic [9:0] irq_id_t;

  // ------------------------------------------------------------------
  // Privilege
  // ------------------------------------------------------------------

  // Only user and machine mode exist on this core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

endpackage

/* irq_sample.sv */
// -------------------------------------------------------------------
// Interrupt sample stage
// Flops the interrupt lines into mip and forms the pending vector
// -------------------------------------------------------------------

`timescale 1ns/1ns

`include "irq_settings.svh"

module irq_sample
  import irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  // External interrupt lines and local enables
  input  irq_vec_t irq_i,
  input  irq_vec_t mie_i,

  output irq_vec_t mip_o,
  output irq_vec_t pending_o
);

  irq_vec_t mip_q;

  // Reserved lines are dropped before the flop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & irq_vec_t'(`IRQ_VALID_MASK);
    end
  end

  assign mip_o = mip_q;

  // Pending and locally enabled, shared by arbiter and sleep control
  assign pending_o = mip_q & mie_i;

endmodule

/* irq_settings.svh */
// -------------------------------------------------------------------
// Interrupt and sleep unit settings
// Line count, valid lines, sleep instruction encodings and timing
// -------------------------------------------------------------------

`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// Interrupt lines seen by the core
`define IRQ_NUM 32

// Lines 31..16 are platform interrupts, 11/7/3 are MEI/MTI/MSI
`define IRQ_VALID_MASK 32'hffff_0888

// Acknowledgements the unit may have in flight toward the core
`define IRQ_CREDITS 1

// ------------------------------------------------------------------
// Sleep instructions
// ------------------------------------------------------------------

`define INSTR_WFI 32'h10500073
`define INSTR_WFE 32'h8C000073

// Cycles already spent in writeback before sleep may be entered
`define WFI_SLEEP_DELAY 2

`endif

/* irq_sleep_top.sv */
// -------------------------------------------------------------------
// Interrupt and sleep unit
// Sample and arbitrate pipeline beside the decode and sleep pipeline
// -------------------------------------------------------------------

`timescale 1ns/1ns

module irq_sleep_top
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // ------------------------------------------------------------------
  // Interrupts
  // ------------------------------------------------------------------
  input  irq_vec_t    irq_i,
  input  irq_vec_t    mie_i,
  input  logic        mstatus_mie_i,
  input  priv_lvl_e   priv_lvl_i,
  input  logic        irq_credit_i,
  output logic        irq_ack_o,
  output irq_id_t     irq_id_o,
  output irq_vec_t    mip_o,

  // ------------------------------------------------------------------
  // Writeback and sleep
  // ------------------------------------------------------------------
  input  logic        wb_valid_i,
  input  logic [31:0] wb_rdata_i,
  input  logic        wb_err_i,
  input  logic        wb_kill_i,
  input  logic        debug_mode_i,
  input  logic        dcsr_step_i,
  input  logic        mstatus_tw_i,
  input  logic        debug_req_i,
  input  logic        nmi_pending_i,
  input  logic        wfe_wake_i,
  input  logic [1:0]  instr_outstanding_i,
  input  logic [1:0]  data_outstanding_i,
  input  logic        wbuf_empty_i,
  output logic        core_sleep_o,
  output logic        retire_o
);

  irq_vec_t pending;
  logic     in_wb;
  logic     is_wfe;

  irq_sample i_sample (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_i     (irq_i),
    .mie_i     (mie_i),
    .mip_o     (mip_o),
    .pending_o (pending)
  );

  irq_arbiter i_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pending_i     (pending),
    .mstatus_mie_i (mstatus_mie_i),
    .priv_lvl_i    (priv_lvl_i),
    .irq_credit_i  (irq_credit_i),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  wfi_decode i_decode (
    .wb_valid_i   (wb_valid_i),
    .wb_rdata_i   (wb_rdata_i),
    .wb_err_i     (wb_err_i),
    .wb_kill_i    (wb_kill_i),
    .debug_mode_i (debug_mode_i),
    .dcsr_step_i  (dcsr_step_i),
    .priv_lvl_i   (priv_lvl_i),
    .mstatus_tw_i (mstatus_tw_i),
    .in_wb_o      (in_wb),
    .is_wfe_o     (is_wfe)
  );

  // Same pending vector as the arbiter sees
  sleep_ctrl i_sleep (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .in_wb_i             (in_wb),
    .is_wfe_i            (is_wfe),
    .pending_i           (pending),
    .debug_req_i         (debug_req_i),
    .nmi_pending_i       (nmi_pending_i),
    .wfe_wake_i          (wfe_wake_i),
    .dcsr_step_i         (dcsr_step_i),
    .instr_outstanding_i (instr_outstanding_i),
    .data_outstanding_i  (data_outstanding_i),
    .wbuf_empty_i        (wbuf_empty_i),
    .core_sleep_o        (core_sleep_o),
    .retire_o            (retire_o)
  );

endmodule

/* project.f */
+incdir+.
irq_pkg.sv
irq_sample.sv
irq_arbiter.sv
wfi_decode.sv
sleep_ctrl.sv
irq_sleep_top.sv
tb_clock.sv
tb_irq_sleep.sv

/* sleep_ctrl.sv */
// -------------------------------------------------------------------
// Sleep control
// Writeback residency, block and wake logic, core_sleep_o and retire
// -------------------------------------------------------------------

`timescale 1ns/1ns

`include "irq_settings.svh"

module sleep_ctrl
  import irq_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // From decode
  input  logic       in_wb_i,
  input  logic       is_wfe_i,

  // Wake-up reasons
  input  irq_vec_t   pending_i,
  input  logic       debug_req_i,
  input  logic       nmi_pending_i,
  input  logic       wfe_wake_i,
  input  logic       dcsr_step_i,

  // Bus and write buffer activity
  input  logic [1:0] instr_outstanding_i,
  input  logic [1:0] data_outstanding_i,
  input  logic       wbuf_empty_i,

  output logic       core_sleep_o,
  output logic       retire_o
);

  localparam int DLY = `WFI_SLEEP_DELAY;

  logic [DLY-1:0] hist_q;
  logic [DLY:0]   hist;
  logic           resident;
  logic           blocked;
  logic           wake;

  // ------------------------------------------------------------------
  // Writeback residency
  // ------------------------------------------------------------------

  // Bit 0 is this cycle, bit n is n cycles ago
  assign hist = {hist_q, in_wb_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else begin
      hist_q <= hist[DLY-1:0];
    end
  end

  // Now and in each of the previous DLY cycles
  assign resident = &hist;

  // ------------------------------------------------------------------
  // Block and wake
  // ------------------------------------------------------------------

  assign blocked = (|instr_outstanding_i) ||
                   (|data_outstanding_i)  ||
                   !wbuf_empty_i;

  // Event wake only applies to WFE
  assign wake = (|pending_i)    ||
                debug_req_i     ||
                nmi_pending_i   ||
                (wfe_wake_i && is_wfe_i);

  // Wake drops sleep in the same cycle that retire rises
  assign core_sleep_o = resident && !blocked && !wake && !dcsr_step_i;

  // From the second cycle on, retire on wake.
  // In the first cycle only a single-step retires
  assign retire_o = in_wb_i && ((hist_q[0] && wake) ||
                                (!hist_q[0] && dcsr_step_i));

endmodule

/* tb_clock.sv */
// -------------------------------------------------------------------
// Testbench clock and reset
// 4 ns clock, reset held low for the first 8 cycles
// -------------------------------------------------------------------

`timescale 1ns/1ns

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tb_irq_sleep.sv */
// -------------------------------------------------------------------
// Interrupt and sleep unit testbench
// Random stimulus, checked every cycle against a reference model
// -------------------------------------------------------------------

`timescale 1ns/1ns

`include "irq_settings.svh"

module tb_irq_sleep
  import irq_pkg::*;
();

  localparam int MAX_CYCLES = 6000;

  logic        clk_i, rst_ni;
  irq_vec_t    irq_i, mie_i, mip_o;
  priv_lvl_e   priv_lvl_i;
  irq_id_t     irq_id_o;
  logic        mstatus_mie_i, irq_credit_i, irq_ack_o;
  logic        wb_valid_i, wb_err_i, wb_kill_i;
  logic [31:0] wb_rdata_i;
  logic        debug_mode_i, dcsr_step_i, mstatus_tw_i;
  logic        debug_req_i, nmi_pending_i, wfe_wake_i;
  logic [1:0]  instr_outstanding_i, data_outstanding_i;
  logic        wbuf_empty_i, core_sleep_o, retire_o;

  // Reference model state and the last sampled DUT outputs
  irq_vec_t    mip_m;
  logic [1:0]  hist_m;
  logic        exp_ack, dut_ack, dut_sleep, dut_retire;
  int          credit_m, cycle_cnt, errors, test_start;
  int          tests_run, tests_failed, ack_count, sleep_count;

  tb_clock i_clock (.clk_o(clk_i), .rst_no(rst_ni));

  irq_sleep_top i_dut (.*);

  function automatic logic rand_bit();
    return 1'($urandom);
  endfunction

  // Lines 31 down to 16 first, then 11, 3 and 7
  function automatic irq_id_t winner(irq_vec_t pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i])
        return irq_id_t'(i);
    end
    if (pend[11])
      return irq_id_t'(11);
    if (pend[3])
      return irq_id_t'(3);
    return pend[7] ? irq_id_t'(7) : '0;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic require(input logic ok, input string msg);
    assert (ok) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_start) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic set_idle();
    irq_i               = '0;
    mie_i               = '0;
    mstatus_mie_i       = 1'b0;
    priv_lvl_i          = PRIV_LVL_M;
    irq_credit_i        = 1'b0;
    wb_valid_i          = 1'b0;
    wb_rdata_i          = '0;
    wb_err_i            = 1'b0;
    wb_kill_i           = 1'b0;
    debug_mode_i        = 1'b0;
    dcsr_step_i         = 1'b0;
    mstatus_tw_i        = 1'b0;
    debug_req_i         = 1'b0;
    nmi_pending_i       = 1'b0;
    wfe_wake_i          = 1'b0;
    instr_outstanding_i = '0;
    data_outstanding_i  = '0;
    wbuf_empty_i        = 1'b1;
  endtask

  // ------------------------------------------------------------------
  // Reference model, called once per cycle after the inputs are set
  // ------------------------------------------------------------------

  task automatic check_cycle();
    irq_vec_t pend;
    logic     elig, in_wb, is_wfe, blocked, wake, exp_sleep, exp_retire;
    #1;
    pend    = mip_m & mie_i;
    elig    = (priv_lvl_i == PRIV_LVL_M && mstatus_mie_i) ||
              (priv_lvl_i == PRIV_LVL_U && |pend);
    exp_ack = |pend && elig && credit_m > 0;
    in_wb   = (wb_rdata_i == `INSTR_WFI || wb_rdata_i == `INSTR_WFE) && wb_valid_i &&
              !wb_err_i && !wb_kill_i && !debug_mode_i &&
              !(priv_lvl_i == PRIV_LVL_U && mstatus_tw_i);
    is_wfe  = in_wb && wb_rdata_i == `INSTR_WFE && !dcsr_step_i;
    blocked = |instr_outstanding_i || |data_outstanding_i || !wbuf_empty_i;
    wake    = |pend || debug_req_i || nmi_pending_i || (wfe_wake_i && is_wfe);
    exp_sleep  = in_wb && hist_m == 2'b11 && !blocked && !wake && !dcsr_step_i;
    exp_retire = in_wb && ((hist_m[0] && wake) || (!hist_m[0] && dcsr_step_i));
    check_equal("mip_o", mip_o, mip_m);
    check_equal("reserved bits of mip_o", mip_o & ~irq_vec_t'(`IRQ_VALID_MASK), '0);
    check_equal("irq_ack_o", 32'(irq_ack_o), 32'(exp_ack));
    check_equal("irq_id_o", 32'(irq_id_o), exp_ack ? 32'(winner(pend)) : 32'h0);
    require(!(irq_ack_o && dut_ack), "irq_ack_o was held high for two cycles in a row");
    check_equal("core_sleep_o", 32'(core_sleep_o), 32'(exp_sleep));
    check_equal("retire_o", 32'(retire_o), 32'(exp_retire));
    dut_ack    = irq_ack_o;
    dut_sleep  = core_sleep_o;
    dut_retire = retire_o;
    if (irq_ack_o)
      ack_count++;
    if (core_sleep_o)
      sleep_count++;
    @(posedge clk_i);
    // Model state moves on the same edge as the DUT flops
    mip_m = irq_i & `IRQ_VALID_MASK;
    if (irq_credit_i && !exp_ack && credit_m < `IRQ_CREDITS)
      credit_m++;
    else if (exp_ack && !irq_credit_i)
      credit_m--;
    hist_m = {hist_m[0], in_wb};
  endtask

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------

  task automatic test_mip();
    repeat (300) begin
      @(negedge clk_i);
      irq_i = $urandom;
      check_cycle();
    end
    report_test("mip sampling");
  endtask

  task automatic test_arbitration();
    int acks;
    acks = ack_count;
    repeat (1500) begin
      @(negedge clk_i);
      irq_i = $urandom;
      // Half the time only the local lines, so 11, 3 and 7 also win
      if (rand_bit())
        irq_i[31:16] = '0;
      mie_i         = $urandom;
      mstatus_mie_i = rand_bit();
      priv_lvl_i    = rand_bit() ? PRIV_LVL_M : PRIV_LVL_U;
      // Handler gives the credit back one cycle after each acknowledge
      irq_credit_i  = exp_ack;
      check_cycle();
    end
    @(negedge clk_i);
    set_idle();
    irq_credit_i = exp_ack;
    check_cycle();
    require(ack_count > acks, "no interrupt was acknowledged during arbitration");
    report_test("arbitration");
  endtask

  task automatic test_credit();
    int acks;
    int hold;
    repeat (20) begin
      hold = 2 + int'($urandom % 8);
      @(negedge clk_i);
      set_idle();
      irq_i         = ($urandom & `IRQ_VALID_MASK) | 32'h0000_0080;
      mie_i         = '1;
      mstatus_mie_i = 1'b1;
      irq_credit_i  = 1'b1;
      check_cycle();
      @(negedge clk_i);
      irq_credit_i = 1'b0;
      acks = ack_count;
      check_cycle();
      check_equal("irq_ack_o after credit return", 32'(dut_ack), 32'h1);
      // Credit withheld, the winner keeps waiting
      repeat (hold) begin
        @(negedge clk_i);
        check_cycle();
      end
      require(ack_count == acks + 1, "a second acknowledge was issued without a credit");
    end
    report_test("credit flow");
  endtask

  task automatic test_sleep_entry();
    int   len;
    int   sleeps;
    logic blk;
    sleeps = sleep_count;
    repeat (40) begin
      len = 3 + int'($urandom % 6);
      blk = ($urandom % 3 == 0);
      @(negedge clk_i);
      set_idle();
      check_cycle();
      for (int c = 1; c <= len; c++) begin
        @(negedge clk_i);
        wb_valid_i = 1'b1;
        wb_rdata_i = `INSTR_WFI;
        if (blk) begin
          instr_outstanding_i = 2'($urandom);
          data_outstanding_i  = 2'($urandom);
          wbuf_empty_i        = rand_bit();
        end
        check_cycle();
        if (c < 3)
          check_equal("core_sleep_o before the third cycle", 32'(dut_sleep), 32'h0);
      end
    end
    require(sleep_count > sleeps, "the core never went to sleep");
    report_test("sleep entry");
  endtask

  task automatic test_wake();
    int   kind;
    logic wfe;
    logic woken;
    repeat (30) begin
      kind  = int'($urandom % 4);
      wfe   = rand_bit();
      woken = (kind != 3) || wfe;
      @(negedge clk_i);
      set_idle();
      // Line 3 sits in mip but stays disabled until the wake
      irq_i = 32'h0000_0008;
      check_cycle();
      repeat (3) begin
        @(negedge clk_i);
        wb_valid_i = 1'b1;
        wb_rdata_i = wfe ? `INSTR_WFE : `INSTR_WFI;
        check_cycle();
      end
      check_equal("core_sleep_o in the third cycle", 32'(dut_sleep), 32'h1);
      @(negedge clk_i);
      case (kind)
        0:       mie_i         = '1;
        1:       debug_req_i   = 1'b1;
        2:       nmi_pending_i = 1'b1;
        default: wfe_wake_i    = 1'b1;
      endcase
      check_cycle();
      check_equal("retire_o on wake", 32'(dut_retire), 32'(woken));
      check_equal("core_sleep_o on wake", 32'(dut_sleep), 32'(!woken));
    end
    report_test("wake and retire");
  endtask

  task automatic test_invalidation();
    int   kind;
    logic wfe;
    repeat (30) begin
      kind = int'($urandom % 4);
      wfe  = rand_bit();
      @(negedge clk_i);
      set_idle();
      check_cycle();
      for (int c = 1; c <= 4; c++) begin
        @(negedge clk_i);
        wb_valid_i = 1'b1;
        wb_rdata_i = wfe ? `INSTR_WFE : `INSTR_WFI;
        case (kind)
          0: wb_kill_i    = 1'b1;
          1: debug_mode_i = 1'b1;
          2: begin
            priv_lvl_i   = PRIV_LVL_U;
            mstatus_tw_i = 1'b1;
          end
          default: dcsr_step_i = 1'b1;
        endcase
        check_cycle();
        check_equal("core_sleep_o while invalid", 32'(dut_sleep), 32'h0);
        check_equal("retire_o while invalid", 32'(dut_retire), 32'(kind == 3 && c == 1));
      end
    end
    report_test("invalidation");
  endtask

  initial begin
    void'($urandom(32'h27ace92e));
    set_idle();
    mip_m        = '0;
    hist_m       = '0;
    credit_m     = `IRQ_CREDITS;
    exp_ack      = 1'b0;
    dut_ack      = 1'b0;
    errors       = 0;
    test_start   = 0;
    tests_run    = 0;
    tests_failed = 0;
    ack_count    = 0;
    sleep_count  = 0;
    wait (rst_ni === 1'b1);
    test_mip();
    test_arbitration();
    test_credit();
    test_sleep_entry();
    test_wake();
    test_invalidation();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* wfi_decode.sv */
// -------------------------------------------------------------------
// WFI/WFE decode
// Flags an eligible WFI or WFE sitting in the writeback stage
// -------------------------------------------------------------------

`timescale 1ns/1ns

`include "irq_settings.svh"

module wfi_decode
  import irq_pkg::*;
(
  // Writeback stage
  input  logic        wb_valid_i,
  input  logic [31:0] wb_rdata_i,
  input  logic        wb_err_i,
  input  logic        wb_kill_i,

  input  logic        debug_mode_i,
  input  logic        dcsr_step_i,
  input  priv_lvl_e   priv_lvl_i,
  input  logic        mstatus_tw_i,

  output logic        in_wb_o,
  output logic        is_wfe_o
);

  logic is_wfi_word;
  logic is_wfe_word;
  logic tw_trap;
  logic invalid;

  assign is_wfi_word = (wb_rdata_i == `INSTR_WFI);
  assign is_wfe_word = (wb_rdata_i == `INSTR_WFE);

  // U-mode with timeout-wait traps instead of sleeping
  assign tw_trap = (priv_lvl_i == PRIV_LVL_U) && mstatus_tw_i;

  assign invalid = !wb_valid_i   ||
                   wb_err_i      ||
                   wb_kill_i     ||
                   debug_mode_i  ||
                   tw_trap;

  // Single-step keeps the instruction visible here. Sleep control
  // retires it in its first cycle and never lets it sleep
  assign in_wb_o = (is_wfi_word || is_wfe_word) && !invalid;

  // A stepped WFE retires at once, so it never waits for an event
  assign is_wfe_o = is_wfe_word && !invalid && !dcsr_step_i;

endmodule
